// File: common/sifhPkg.sv
package sifhPkg;

    // ====================
    // Frame geometry
    // ====================

    // Sample and result width.
    localparam int Np = 10;

    // Pixels packed into one result word.
    localparam int pixelNumPerRam = 3;

    // Taps per pixel and rows per frame.
    localparam int tapNum = 2;
    localparam int rowNum = 2;

    // Row, pixel, tap order gives 12 samples per frame.
    localparam int samplesPerFrame = rowNum * pixelNumPerRam * tapNum;

    // ====================
    // Histogram
    // ====================

    // Four coarse bins taken from the top two sample bits.
    localparam int binNum = 4;

    // Each bin spans 2**binLog2Width codes (256 for Np = 10).
    localparam int binLog2Width = Np - $clog2(binNum);

    // Largest count per pixel is rowNum * tapNum = 4.
    localparam int binCountWidth = 3;

    // ====================
    // Types
    // ====================

    typedef logic [Np-1:0] sampleT;
    typedef logic [1:0]    pixelIdxT;
    typedef logic [1:0]    binIdxT;

    typedef enum logic {
        idle,
        inFrame
    } seqStateT;

    // Raw sample with its frame position, 15 bits.
    typedef struct packed {
        sampleT   data;
        pixelIdxT pixel;
        logic     tap;
        logic     first;
        logic     last;
    } taggedSampleT;

    // Counts indexed as count[pixel][bin], 36 bits.
    typedef struct packed {
        logic [pixelNumPerRam-1:0][binNum-1:0][binCountWidth-1:0] count;
    } binCountsT;

    // Largest sample seen by each pixel, 30 bits.
    typedef struct packed {
        sampleT [pixelNumPerRam-1:0] peak;
    } peaksT;

    // Pixel 0 sits in the low Np bits.
    typedef sampleT [pixelNumPerRam-1:0] resultT;

endpackage

// File: source/sampleSequencer.sv
`timescale 1ns/1ps

module sampleSequencer (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wrEn,
    input  sifhPkg::sampleT       data,
    output sifhPkg::taggedSampleT tag,
    output logic                  tagValid,
    output logic                  frameEnd
);
    import sifhPkg::*;

    seqStateT state;
    logic     tapCnt;
    pixelIdxT pixelCnt;
    logic     rowCnt;

    logic     lastTap;
    logic     lastPixel;
    logic     lastRow;
    logic     lastSample;

    // ====================
    // Position counters
    // ====================

    assign lastTap    = (tapCnt == 1'(tapNum - 1));
    assign lastPixel  = (pixelCnt == pixelIdxT'(pixelNumPerRam - 1));
    assign lastRow    = (rowCnt == 1'(rowNum - 1));
    assign lastSample = lastTap && lastPixel && lastRow;

    // Tap runs fastest, then pixel, then row.
    // All three wrap to zero together on the last sample.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= idle;
            tapCnt   <= 1'b0;
            pixelCnt <= '0;
            rowCnt   <= 1'b0;
        end else if (wrEn) begin
            state  <= lastSample ? idle : inFrame;
            tapCnt <= lastTap ? 1'b0 : tapCnt + 1'b1;
            if (lastTap) begin
                pixelCnt <= lastPixel ? pixelIdxT'(0) : pixelCnt + 1'b1;
            end
            if (lastTap && lastPixel) begin
                rowCnt <= lastRow ? 1'b0 : rowCnt + 1'b1;
            end
        end
    end

    // ====================
    // Tag output
    // ====================

    // Payload only; tagValid qualifies it.
    always_ff @(posedge clk) begin
        if (wrEn) begin
            tag <= '{
                data:  data,
                pixel: pixelCnt,
                tap:   tapCnt,
                first: (state == idle),
                last:  lastSample
            };
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            tagValid <= 1'b0;
            frameEnd <= 1'b0;
        end else begin
            tagValid <= wrEn;
            // Side blocks hold the final frame values in this cycle.
            frameEnd <= tagValid && tag.last;
        end
    end

    // A frame end only follows a valid last tag at the final tap of the final pixel.
    assert property (@(posedge clk) disable iff (!rstN)
        frameEnd |-> $past(tagValid && tag.last
                           && tag.tap == 1'(tapNum - 1)
                           && tag.pixel == pixelIdxT'(pixelNumPerRam - 1)));

endmodule

// File: histogram/binAccumulator.sv
`timescale 1ns/1ps

module binAccumulator (
    input  logic                  clk,
    input  logic                  rstN,
    input  sifhPkg::taggedSampleT tag,
    input  logic                  tagValid,
    output sifhPkg::binCountsT    binCounts
);
    import sifhPkg::*;

    binIdxT    sampleBin;
    binCountsT nextCounts;

    // ====================
    // Bin select
    // ====================

    // Coarse bin is the top bits of the sample.
    assign sampleBin = binIdxT'(tag.data >> binLog2Width);

    // ====================
    // Count update
    // ====================

    // A first tag starts from an empty histogram for every pixel,
    // otherwise the tagged pixel's bin is bumped in place.
    always_comb begin
        nextCounts = binCounts;
        if (tag.first) begin
            nextCounts = '0;
        end
        nextCounts.count[tag.pixel][sampleBin] =
            nextCounts.count[tag.pixel][sampleBin] + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            binCounts <= '0;
        end else if (tagValid) begin
            binCounts <= nextCounts;
        end
    end

    // The sequencer's framing keeps each pixel to rowNum * tapNum samples,
    // so an increment never starts from a saturated count.
    assert property (@(posedge clk) disable iff (!rstN)
        (tagValid && !tag.first) |->
            (binCounts.count[tag.pixel][sampleBin] != '1));

endmodule

// File: histogram/peakTracker.sv
`timescale 1ns/1ps

module peakTracker (
    input  logic                  clk,
    input  logic                  rstN,
    input  sifhPkg::taggedSampleT tag,
    input  logic                  tagValid,
    output sifhPkg::peaksT        peaks
);
    import sifhPkg::*;

    peaksT  nextPeaks;
    sampleT currentPeak;

    // ====================
    // Peak update
    // ====================

    // Peak of the tagged pixel before this sample; zero on a new frame.
    assign currentPeak = tag.first ? sampleT'(0) : peaks.peak[tag.pixel];

    always_comb begin
        nextPeaks = peaks;
        if (tag.first) begin
            nextPeaks = '0;
        end
        // First sample of a frame always loads, since the base is zero.
        if (tag.data > currentPeak) begin
            nextPeaks.peak[tag.pixel] = tag.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            peaks <= '0;
        end else if (tagValid) begin
            peaks <= nextPeaks;
        end
    end

endmodule

// File: source/resultCombiner.sv
`timescale 1ns/1ps

module resultCombiner (
    input  logic               clk,
    input  logic               rstN,
    input  logic               frameEnd,
    input  sifhPkg::binCountsT binCounts,
    input  sifhPkg::peaksT     peaks,
    output sifhPkg::resultT    result,
    output logic               resultValid
);
    import sifhPkg::*;

    binIdxT                   modeBin [pixelNumPerRam];
    logic [binCountWidth-1:0] bestCount [pixelNumPerRam];
    sampleT                   binCenter [pixelNumPerRam];
    resultT                   nextResult;

    // ====================
    // Mode bin search
    // ====================

    // Strict compare, so the lowest bin index wins a tie.
    always_comb begin
        for (int p = 0; p < pixelNumPerRam; p++) begin
            modeBin[p]   = '0;
            bestCount[p] = binCounts.count[p][0];
            for (int b = 1; b < binNum; b++) begin
                if (binCounts.count[p][b] > bestCount[p]) begin
                    modeBin[p]   = binIdxT'(b);
                    bestCount[p] = binCounts.count[p][b];
                end
            end
        end
    end

    // ====================
    // Pixel value
    // ====================

    // Center of the mode bin, capped by the pixel's peak.
    always_comb begin
        for (int p = 0; p < pixelNumPerRam; p++) begin
            binCenter[p] = (sampleT'(modeBin[p]) << binLog2Width)
                         | (sampleT'(1) << (binLog2Width - 1));
            if (peaks.peak[p] < binCenter[p]) begin
                nextResult[p] = peaks.peak[p];
            end else begin
                nextResult[p] = binCenter[p];
            end
        end
    end

    // Result holds until the next frame end.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= frameEnd;
            if (frameEnd) begin
                result <= nextResult;
            end
        end
    end

    // Frames are 12 samples long, so valid can never repeat back to back.
    assert property (@(posedge clk) disable iff (!rstN)
        resultValid |=> !resultValid);

endmodule

// File: source/hisBuilderFSM.sv
`timescale 1ns/1ps

module hisBuilderFSM (
    input  logic            clk,
    input  logic            rstN,
    input  logic            wrEn,
    input  sifhPkg::sampleT data,
    output sifhPkg::resultT result,
    output logic            resultValid
);
    import sifhPkg::*;

    taggedSampleT tag;
    logic         tagValid;
    logic         frameEnd;
    binCountsT    binCounts;
    peaksT        peaks;

    // ====================
    // Front end
    // ====================

    sampleSequencer sampleSequencerU0 (
        .clk      (clk),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .data     (data),
        .tag      (tag),
        .tagValid (tagValid),
        .frameEnd (frameEnd)
    );

    // ====================
    // Histogram blocks
    // ====================

    // Both see the same tag stream in parallel.
    binAccumulator binAccumulatorU0 (
        .clk       (clk),
        .rstN      (rstN),
        .tag       (tag),
        .tagValid  (tagValid),
        .binCounts (binCounts)
    );

    peakTracker peakTrackerU0 (
        .clk      (clk),
        .rstN     (rstN),
        .tag      (tag),
        .tagValid (tagValid),
        .peaks    (peaks)
    );

    // Frame end lines up with the final counts and peaks.
    resultCombiner resultCombinerU0 (
        .clk         (clk),
        .rstN        (rstN),
        .frameEnd    (frameEnd),
        .binCounts   (binCounts),
        .peaks       (peaks),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

// File: dv/hisBuilderTb.sv
`timescale 1ns/1ps

module hisBuilderTb;
    import sifhPkg::*;

    // ====================
    // Constants and types
    // ====================

    localparam int binWidth       = (1 << Np) / binNum;
    localparam int validCycle     = 3;
    localparam int validLimit     = 16;
    localparam int idleLimit      = 5000;
    localparam int drainLimit     = 100;
    localparam int randomFrameNum = 200;
    localparam int testCount      = 6;

    // Index 0 is the first sample of the frame.
    typedef sampleT [samplesPerFrame-1:0] frameT;

    logic   clk = 1'b0;
    logic   rstN;
    logic   wrEn;
    sampleT data;
    resultT result;
    logic   resultValid;

    int          cycleCnt      = 0;
    int          errorCount    = 0;
    int          checkCount    = 0;
    int          framesSent    = 0;
    int          framesChecked = 0;
    bit          compareStuck  = 1'b0;
    logic [31:0] rngState      = 32'ha68fbdf8;
    resultT      expQ [$];
    int          acceptQ [$];

    hisBuilderFSM DUT (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid)
    );

    always #20 clk = ~clk;

    // Number of rising edges seen so far.
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    // ====================
    // Stimulus helpers
    // ====================

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Mode bin per pixel with ties to the lower bin, bounded by the pixel's peak.
    function automatic resultT expectedResult(frameT f);
        int     counts [pixelNumPerRam][binNum];
        int     peak [pixelNumPerRam];
        int     pixel;
        int     best;
        int     center;
        resultT r;
        for (int p = 0; p < pixelNumPerRam; p++) begin
            peak[p] = 0;
            for (int b = 0; b < binNum; b++) begin
                counts[p][b] = 0;
            end
        end
        for (int i = 0; i < samplesPerFrame; i++) begin
            // Tap runs fastest, then pixel, then row.
            pixel = (i / tapNum) % pixelNumPerRam;
            counts[pixel][int'(f[i]) / binWidth]++;
            if (int'(f[i]) > peak[pixel]) begin
                peak[pixel] = int'(f[i]);
            end
        end
        for (int p = 0; p < pixelNumPerRam; p++) begin
            best = 0;
            for (int b = 1; b < binNum; b++) begin
                if (counts[p][b] > counts[p][best]) begin
                    best = b;
                end
            end
            center = best * binWidth + binWidth / 2;
            r[p] = sampleT'((peak[p] < center) ? peak[p] : center);
        end
        return r;
    endfunction

    task automatic sendFrame(frameT f, bit withGaps);
        int gapLen;
        for (int i = 0; i < samplesPerFrame; i++) begin
            gapLen = 0;
            if (withGaps && nextRandom() % 4 == 0) begin
                gapLen = 1 + int'(nextRandom() % 3);
            end
            // Data keeps moving during a gap and must be ignored.
            for (int g = 0; g < gapLen; g++) begin
                wrEn = 1'b0;
                data = sampleT'(nextRandom());
                @(posedge clk);
                #2;
            end
            wrEn = 1'b1;
            data = f[i];
            if (i == samplesPerFrame - 1) begin
                expQ.push_back(expectedResult(f));
                acceptQ.push_back(cycleCnt + 1);
                framesSent++;
            end
            @(posedge clk);
            #2;
        end
    endtask

    // ====================
    // Compare tasks
    // ====================

    task automatic checkResult(string name, resultT got, resultT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkLatency(int got, int exp);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: resultValid latency got %0d, expected %0d",
                     $time, got, exp);
        end
    endtask

    // Valid must drop again one cycle after it rose.
    task automatic checkValidPulse();
        @(negedge clk);
        checkCount++;
        if (resultValid !== 1'b0) begin
            errorCount++;
            $display("CHECK FAILED at %0t: resultValid got %b, expected %b",
                     $time, resultValid, 1'b0);
        end
    endtask

    // ====================
    // Comparing process
    // ====================

    initial begin : compareProcess
        int     waitCycles;
        bit     gotValid;
        resultT exp;
        int     acceptEdge;
        for (int i = 0; i < 10 && rstN !== 1'b1; i++) begin
            @(negedge clk);
        end
        while (!compareStuck) begin
            waitCycles = 0;
            while (framesSent == framesChecked && waitCycles < idleLimit) begin
                @(negedge clk);
                waitCycles++;
                if (resultValid !== 1'b0 && framesSent == framesChecked) begin
                    errorCount++;
                    $display("CHECK FAILED at %0t: resultValid got %b, expected %b",
                             $time, resultValid, 1'b0);
                end
            end
            if (framesSent == framesChecked) begin
                errorCount++;
                compareStuck = 1'b1;
                $display("Error: no frame arrived within %0d cycles", idleLimit);
            end else begin
                gotValid = 1'b0;
                for (int i = 0; i < validLimit && !gotValid; i++) begin
                    @(negedge clk);
                    gotValid = (resultValid === 1'b1);
                end
                if (!gotValid) begin
                    errorCount++;
                    compareStuck = 1'b1;
                    $display("Error: resultValid did not rise within %0d cycles of a frame",
                             validLimit);
                end else begin
                    exp        = expQ.pop_front();
                    acceptEdge = acceptQ.pop_front();
                    // The cycle right after the accepting edge counts as the first.
                    checkLatency(cycleCnt - acceptEdge + 1, validCycle);
                    checkResult("result", result, exp);
                    checkValidPulse();
                    framesChecked++;
                end
            end
        end
    end

    // ====================
    // Tests
    // ====================

    task automatic idleAfterReset();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            checkResult("result", result, '0);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic fixedFramePair();
        frameT a;
        frameT b;
        // Rightmost entry is sample 0.
        a = {10'd990, 10'd15, 10'd600, 10'd610, 10'd140, 10'd260,
             10'd700, 10'd20, 10'd515, 10'd620, 10'd130, 10'd270};
        b = {10'd1000, 10'd900, 10'd450, 10'd300, 10'd5, 10'd100,
             10'd800, 10'd780, 10'd400, 10'd333, 10'd60, 10'd90};
        sendFrame(a, 1'b0);
        sendFrame(b, 1'b0);
    endtask

    // Everything in bin 2 and below its center of 640.
    task automatic peakBelowCenter();
        frameT f;
        for (int i = 0; i < samplesPerFrame; i++) begin
            f[i] = sampleT'(512 + 9 * i);
        end
        sendFrame(f, 1'b0);
    endtask

    // Row 0 lands in bin 3, row 1 in bin 1, two each per pixel.
    task automatic tiedBins();
        frameT f;
        for (int i = 0; i < samplesPerFrame; i++) begin
            f[i] = sampleT'((i < 6) ? 800 + i : 300 + i);
        end
        sendFrame(f, 1'b0);
    endtask

    task automatic randomGappedFrames();
        frameT f;
        for (int n = 0; n < randomFrameNum; n++) begin
            for (int i = 0; i < samplesPerFrame; i++) begin
                f[i] = sampleT'(nextRandom());
            end
            sendFrame(f, 1'b1);
        end
    endtask

    task automatic fullScaleFrame();
        frameT f;
        f = '1;
        sendFrame(f, 1'b0);
    endtask

    function automatic string testName(int t);
        case (t)
            1: return "idle after reset";
            2: return "fixed frame pair";
            3: return "peak below center";
            4: return "tied bins";
            5: return "random gapped frames";
            default: return "full scale frame";
        endcase
    endfunction

    task automatic waitDrain(output bit timedOut);
        int waited;
        waited = 0;
        while (framesSent != framesChecked && !compareStuck && waited < drainLimit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        timedOut = compareStuck || (framesSent != framesChecked);
        if (framesSent != framesChecked && !compareStuck) begin
            $display("Error: %0d frame results still pending after %0d cycles",
                     framesSent - framesChecked, drainLimit);
        end
    endtask

    task automatic endRun(int testsRun, int failedTests, bit timedOut);
        $display("Tests run: %0d, with errors: %0d, checks: %0d, errors: %0d",
                 testsRun, failedTests, checkCount, errorCount);
        if (errorCount == 0 && failedTests == 0 && !timedOut) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin : mainProcess
        int errorsBefore;
        int testsRun;
        int failedTests;
        bit timedOut;
        rstN        = 1'b0;
        wrEn        = 1'b0;
        data        = '0;
        testsRun    = 0;
        failedTests = 0;
        timedOut    = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int t = 1; t <= testCount && !timedOut; t++) begin
            errorsBefore = errorCount;
            case (t)
                1: idleAfterReset();
                2: fixedFramePair();
                3: peakBelowCenter();
                4: tiedBins();
                5: randomGappedFrames();
                default: fullScaleFrame();
            endcase
            wrEn = 1'b0;
            waitDrain(timedOut);
            testsRun++;
            if (errorCount != errorsBefore || timedOut) begin
                failedTests++;
            end
            $display("Test %0d (%s): %s", t, testName(t),
                     (errorCount == errorsBefore && !timedOut) ? "ok" : "errors");
        end
        endRun(testsRun, failedTests, timedOut);
    end

endmodule

// File: vlog.f
common/sifhPkg.sv
source/sampleSequencer.sv
histogram/binAccumulator.sv
histogram/peakTracker.sv
source/resultCombiner.sv
source/hisBuilderFSM.sv
dv/hisBuilderTb.sv

// File: Makefile
# Verilator build and run of the histogram builder testbench.

VERILATOR ?= verilator
TOP       ?= hisBuilderTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

# The run counts as passing only if the log holds the pass message.
simulate:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
